// File: rtl/I2CKeyPad_cfg.svh
// Build-time settings for the keypad I2C master
// Included by the RTL modules that need bus timing, addresses or widths
`ifndef I2C_KEYPAD_CFG_SVH
`define I2C_KEYPAD_CFG_SVH

// ----------------------------------------
// Bus timing
// ----------------------------------------
`define I2C_QUARTER_CYCLES 5           // iSCLK cycles per quarter SCL period, 4 or more

// ----------------------------------------
// Slave addresses and transfer shape
// ----------------------------------------
`define I2C_KEYPAD1_ADRS   8'h02       // Left keypad
`define I2C_KEYPAD2_ADRS   8'h03       // Right keypad
`define I2C_GYRO_ADRS      8'h04       // Gyro, not polled yet
`define I2C_BUF_LEN        8'd2        // Address byte + one read byte

`define I2C_DATA_W         8           // One bus byte
`define I2C_KEY_W          16          // Both keypads packed

`endif

// File: rtl/I2CPkg.sv
// Shared state types for the keypad I2C master
// Modules refer to these by scoped name
`default_nettype none

package I2CPkg;

	// ----------------------------------------
	// Sequencer, one state per polled slave
	// ----------------------------------------
	typedef enum logic [2:0]
	{
		DevStop = 3'd0,     // Waiting for CSR enable
		DevKey1 = 3'd1,     // Polling keypad 1
		DevKey2 = 3'd2,     // Polling keypad 2
		DevComp = 3'd3      // Word ready, hold until enable drops
	} deviceSel_t;

	// ----------------------------------------
	// Byte engine
	// ----------------------------------------
	typedef enum logic [2:0]
	{
		MsIdle  = 3'd0,
		MsStart = 3'd1,     // SDA falls while SCL high
		MsBit   = 3'd2,     // Eight data bits, MSB first
		MsAck   = 3'd3,
		MsStop  = 3'd4,     // SDA rises while SCL high
		MsFree  = 3'd5      // Bus free time before next sample of enable
	} masterState_t;

endpackage

`default_nettype wire

// File: rtl/I2CMasterMux.sv
// Keypad polling sequencer in front of the byte engine
// Runs keypad 1 then keypad 2, one address + read transaction each,
// and holds the collected keypad word until the CSR enable falls
`default_nettype none
`include "I2CKeyPad_cfg.svh"

module I2CMasterMux (
	input  wire                     iSCLK,
	input  wire                     iSRST,
	input  wire                     iI2CEn,         // CSR enable
	input  wire                     iI2CBufVd,      // Transaction done
	input  wire                     iI2CByteVd,     // Byte plus ack done
	input  wire  [`I2C_DATA_W-1:0]  iSdaByte,       // Last byte shifted in
	output logic [`I2C_KEY_W-1:0]   oI2CGetKeyPad,
	output logic                    oI2CSeqComp,
	output logic                    oTriState,      // 0 drive SDA, 1 release
	output logic [`I2C_DATA_W-1:0]  oI2CSend,
	output logic [`I2C_DATA_W-1:0]  oI2CBufLen,
	output logic                    oI2CEn          // Engine enable
);

	I2CPkg::deviceSel_t rDeviceSel;

	// Fixed transfer length for keypads
	assign oI2CBufLen = `I2C_BUF_LEN;

	// ----------------------------------------
	// Device select FSM
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rDeviceSel <= I2CPkg::DevStop;
		else
		begin
			case (rDeviceSel)
				I2CPkg::DevStop:
					if (iI2CEn)
						rDeviceSel <= I2CPkg::DevKey1;
				I2CPkg::DevKey1:
					if (iI2CBufVd)
						rDeviceSel <= I2CPkg::DevKey2;
				I2CPkg::DevKey2:
					if (iI2CBufVd)
						rDeviceSel <= I2CPkg::DevComp;
				I2CPkg::DevComp:
					if (!iI2CEn)
						rDeviceSel <= I2CPkg::DevStop;    // Rearm for next poll
				default:
					rDeviceSel <= I2CPkg::DevStop;
			endcase
		end
	end

	// Engine enable and completion, one cycle behind the state
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oI2CEn      <= 1'b0;
			oI2CSeqComp <= 1'b0;
		end
		else
		begin
			oI2CEn      <= (rDeviceSel == I2CPkg::DevKey1) ||
			               (rDeviceSel == I2CPkg::DevKey2);
			oI2CSeqComp <= (rDeviceSel == I2CPkg::DevComp);
		end
	end

	// Address byte for the slave being polled
	always_ff @(posedge iSCLK)
	begin
		case (rDeviceSel)
			I2CPkg::DevKey1: oI2CSend <= `I2C_KEYPAD1_ADRS;
			I2CPkg::DevKey2: oI2CSend <= `I2C_KEYPAD2_ADRS;
			default:         oI2CSend <= oI2CSend;      // Keep last address
		endcase
	end

	// ----------------------------------------
	// SDA direction and received data
	// ----------------------------------------
	// Address byte is written, read byte is released, so flip per byte
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || !iI2CEn)
			oTriState <= 1'b0;
		else if (iI2CByteVd)
			oTriState <= ~oTriState;
	end

	// Keypad 1 ends up in the upper byte
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oI2CGetKeyPad <= '0;
		else if (iI2CBufVd)
			oI2CGetKeyPad <= {oI2CGetKeyPad[`I2C_KEY_W-`I2C_DATA_W-1:0], iSdaByte};
	end

endmodule

`default_nettype wire

// File: rtl/I2CMaster.sv
// Byte-level I2C master engine, single bus, no clock stretching
// Sends start, iI2CBufLen bytes with ack bits, then stop and free time
// SCL is push-pull; SDA is only ever pulled low through oSdaLow
`default_nettype none
`include "I2CKeyPad_cfg.svh"

module I2CMaster (
	input  wire                     iSCLK,
	input  wire                     iSRST,
	input  wire                     iI2CEn,
	input  wire  [`I2C_DATA_W-1:0]  iI2CSend,       // First byte of transaction
	input  wire  [`I2C_DATA_W-1:0]  iI2CBufLen,
	input  wire                     iTriState,      // 1 means receive this byte
	input  wire                     iSda,           // Resolved bus level
	output logic                    oI2CByteVd,
	output logic                    oI2CBufVd,
	output logic [`I2C_DATA_W-1:0]  oSdaByte,
	output logic                    oScl,
	output logic                    oSdaLow
);

	localparam int QtrW = $clog2(`I2C_QUARTER_CYCLES);

	I2CPkg::masterState_t rState;
	logic [QtrW-1:0]        rQtrCnt;        // Cycles within a quarter
	logic [1:0]             rPhase;         // Quarter within a bit
	logic [2:0]             rBitCnt;
	logic [`I2C_DATA_W-1:0] rByteCnt;
	logic [`I2C_DATA_W-1:0] rShift;
	logic                   qtrTick;        // Last cycle of a quarter

	assign qtrTick  = (rQtrCnt == QtrW'(`I2C_QUARTER_CYCLES - 1));
	assign oSdaByte = rShift;

	// ----------------------------------------
	// Quarter period pacing
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || rState == I2CPkg::MsIdle)
			rQtrCnt <= '0;                  // Aligned start on leaving idle
		else if (qtrTick)
			rQtrCnt <= '0;
		else
			rQtrCnt <= rQtrCnt + 1'b1;
	end

	// ----------------------------------------
	// Bus FSM
	// ----------------------------------------
	// Each state spans four quarters; actions land on the quarter ends
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rState     <= I2CPkg::MsIdle;
			rPhase     <= 2'd0;
			rBitCnt    <= 3'd0;
			rByteCnt   <= '0;
			oScl       <= 1'b1;
			oSdaLow    <= 1'b0;
			oI2CByteVd <= 1'b0;
			oI2CBufVd  <= 1'b0;
		end
		else
		begin
			oI2CByteVd <= 1'b0;             // Strobes by default
			oI2CBufVd  <= 1'b0;
			if (rState == I2CPkg::MsIdle)
			begin
				rPhase <= 2'd0;
				if (iI2CEn)
				begin
					rState   <= I2CPkg::MsStart;
					rByteCnt <= '0;
				end
			end
			else if (qtrTick)
			begin
				rPhase <= rPhase + 2'd1;
				case (rState)
					I2CPkg::MsStart:
						case (rPhase)
							2'd0: oSdaLow <= 1'b1;      // Start condition
							2'd2: oScl    <= 1'b0;
							2'd3:
							begin
								rState  <= I2CPkg::MsBit;
								rBitCnt <= 3'd0;
							end
							default: oSdaLow <= 1'b1;
						endcase
					I2CPkg::MsBit:
						case (rPhase)
							2'd0: oSdaLow <= ~iTriState & ~rShift[`I2C_DATA_W-1];
							2'd1: oScl    <= 1'b1;      // Rising SCL, data sampled
							2'd3:
							begin
								oScl <= 1'b0;
								if (rBitCnt == 3'd7)
									rState <= I2CPkg::MsAck;
								else
									rBitCnt <= rBitCnt + 3'd1;
							end
							default: oScl <= 1'b1;
						endcase
					I2CPkg::MsAck:
						case (rPhase)
							2'd0: oSdaLow <= iTriState; // ACK a read, release after a write
							2'd1: oScl    <= 1'b1;      // Slave ack not checked
							2'd3:
							begin
								oScl       <= 1'b0;
								oI2CByteVd <= 1'b1;
								rBitCnt    <= 3'd0;
								if (rByteCnt == iI2CBufLen - 1'b1)
									rState <= I2CPkg::MsStop;
								else
								begin
									rByteCnt <= rByteCnt + 1'b1;
									rState   <= I2CPkg::MsBit;
								end
							end
							default: oScl <= 1'b1;
						endcase
					I2CPkg::MsStop:
						case (rPhase)
							2'd0: oSdaLow <= 1'b1;      // SDA low under low SCL
							2'd1: oScl    <= 1'b1;
							2'd2: oSdaLow <= 1'b0;      // Stop condition
							default:
							begin
								oI2CBufVd <= 1'b1;
								rState    <= I2CPkg::MsFree;
							end
						endcase
					I2CPkg::MsFree:
						if (rPhase == 2'd3)
							rState <= I2CPkg::MsIdle;   // Sequencer has settled by now
					default:
						rState <= I2CPkg::MsIdle;
				endcase
			end
		end
	end

	// ----------------------------------------
	// Shift register
	// ----------------------------------------
	// Loaded with the address, then takes SDA on every rising SCL
	// For a written byte the bus echoes the driven bits back in
	always_ff @(posedge iSCLK)
	begin
		if (rState == I2CPkg::MsIdle && iI2CEn)
			rShift <= iI2CSend;
		else if (qtrTick && rPhase == 2'd1 && rState == I2CPkg::MsBit)
			rShift <= {rShift[`I2C_DATA_W-2:0], iSda};
	end

endmodule

`default_nettype wire

// File: rtl/I2CKeyPadTop.sv
// Keypad I2C subsystem top level
// Joins the polling sequencer to the byte engine; host sees the
// keypad word and a completion level, the pad ring sees SCL and SDA
`default_nettype none
`include "I2CKeyPad_cfg.svh"

module I2CKeyPadTop (
	input  wire                    iSCLK,
	input  wire                    iSRST,
	input  wire                    iEn,         // CSR enable
	input  wire                    iSda,        // Resolved SDA from pad
	output wire [`I2C_KEY_W-1:0]   oKeyPad,
	output wire                    oSeqComp,
	output wire                    oScl,
	output wire                    oSdaLow      // Open-drain pull-down
);

	// ----------------------------------------
	// Sequencer to engine
	// ----------------------------------------
	wire                    i2cEn;
	wire [`I2C_DATA_W-1:0]  i2cSend;
	wire [`I2C_DATA_W-1:0]  i2cBufLen;
	wire                    triState;
	wire                    i2cByteVd;
	wire                    i2cBufVd;
	wire [`I2C_DATA_W-1:0]  sdaByte;

	I2CMasterMux uMux (
		.iSCLK         (iSCLK),
		.iSRST         (iSRST),
		.iI2CEn        (iEn),
		.iI2CBufVd     (i2cBufVd),
		.iI2CByteVd    (i2cByteVd),
		.iSdaByte      (sdaByte),
		.oI2CGetKeyPad (oKeyPad),
		.oI2CSeqComp   (oSeqComp),
		.oTriState     (triState),
		.oI2CSend      (i2cSend),
		.oI2CBufLen    (i2cBufLen),
		.oI2CEn        (i2cEn)
	);

	I2CMaster uMaster (
		.iSCLK      (iSCLK),
		.iSRST      (iSRST),
		.iI2CEn     (i2cEn),
		.iI2CSend   (i2cSend),
		.iI2CBufLen (i2cBufLen),
		.iTriState  (triState),
		.iSda       (iSda),
		.oI2CByteVd (i2cByteVd),
		.oI2CBufVd  (i2cBufVd),
		.oSdaByte   (sdaByte),
		.oScl       (oScl),
		.oSdaLow    (oSdaLow)
	);

endmodule

`default_nettype wire

// File: test/I2CKeyPadSlave.sv
// Behavioral keypad slave for the I2C testbench
// Answers keypad addresses 02 and 03 with one data byte each and
// counts starts, stops, read bytes and master acks for the checks
`default_nettype none

module I2CKeyPadSlave (
	input  wire         scl,
	input  wire         sda,            // Resolved bus level
	input  wire  [7:0]  key1Byte,       // Returned for address 02
	input  wire  [7:0]  key2Byte,       // Returned for address 03
	output logic        sdaLow,         // Slave pull-down
	output int          txnCnt,         // Start conditions seen
	output int          doneCnt,        // Stop conditions seen
	output int          readCnt,        // Data bytes returned
	output int          ackCnt,         // Read bytes acked by the master
	output logic [15:0] adrsHist        // Last two address bytes
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] adrs;
	logic [7:0] data;
	logic       hit;
	int         bitIdx;

	initial
	begin
		sdaLow   = 1'b0;
		txnCnt   = 0;
		doneCnt  = 0;
		readCnt  = 0;
		ackCnt   = 0;
		adrsHist = 16'h0000;
		adrs     = 8'h00;
		data     = 8'h00;
		forever
		begin
			// Start, SDA falls under high SCL
			@(negedge sda);
			while (scl !== 1'b1)
				@(negedge sda);
			txnCnt++;
			for (bitIdx = 0; bitIdx < 8; bitIdx++)
			begin
				@(posedge scl);
				adrs = {adrs[6:0], sda};    // MSB first
			end
			adrsHist = {adrsHist[7:0], adrs};
			hit      = (adrs == 8'h02) || (adrs == 8'h03);
			@(negedge scl);
			sdaLow = hit;                   // Address ack
			@(negedge scl);
			sdaLow = 1'b0;
			if (hit)
			begin
				data = (adrs == 8'h02) ? key1Byte : key2Byte;
				for (bitIdx = 7; bitIdx >= 0; bitIdx--)
				begin
					sdaLow = ~data[bitIdx];   // Change only under low SCL
					@(negedge scl);
				end
				sdaLow = 1'b0;              // Ack slot belongs to the master
				@(posedge scl);
				readCnt++;
				if (sda === 1'b0)
					ackCnt++;
			end
			// Stop, SDA rises under high SCL
			@(posedge sda);
			while (scl !== 1'b1)
				@(posedge sda);
			doneCnt++;
		end
	end

endmodule

`default_nettype wire

// File: test/I2CKeyPadTb.sv
// Testbench for the keypad I2C subsystem
// Each stim line runs one full poll of both keypads and checks the
// bus traffic, the keypad word and the completion level
`default_nettype none
`include "I2CKeyPad_cfg.svh"

module I2CKeyPadTb;

	timeunit 1ns;
	timeprecision 100ps;

	// One two-byte transaction: start, 9 bits per byte, stop, free time
	localparam int TxnCycles  = (3 + 9 * `I2C_BUF_LEN) * 4 * `I2C_QUARTER_CYCLES;
	localparam int HoldCycles = 8 * 4 * `I2C_QUARTER_CYCLES;   // Long enough to see a stray start
	localparam int TestCycles = 2 * TxnCycles + HoldCycles + 100;

	logic        iSCLK;
	logic        iSRST;
	logic        en;                // CSR enable
	logic [7:0]  key1Byte;
	logic [7:0]  key2Byte;
	wire         sdaBus;
	wire  [15:0] keyPad;
	wire         seqComp;
	wire         scl;
	wire         sdaLowDut;
	wire         sdaLowSlave;
	wire  [15:0] adrsHist;
	int          txnCnt;
	int          doneCnt;
	int          readCnt;
	int          ackCnt;

	int          errCnt = 0;
	int          passTests = 0;
	int          failTests = 0;
	int          cycleCnt = 0;
	int          cycleLimit = 0;
	int          testIdx;
	logic [7:0]  stimKey1[$];
	logic [7:0]  stimKey2[$];
	logic [15:0] stimWord[$];

	// Open-drain bus with pull-up
	assign sdaBus = !((sdaLowDut === 1'b1) || (sdaLowSlave === 1'b1));

	I2CKeyPadTop DUT (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.iEn      (en),
		.iSda     (sdaBus),
		.oKeyPad  (keyPad),
		.oSeqComp (seqComp),
		.oScl     (scl),
		.oSdaLow  (sdaLowDut)
	);

	I2CKeyPadSlave uSlave (
		.scl      (scl),
		.sda      (sdaBus),
		.key1Byte (key1Byte),
		.key2Byte (key2Byte),
		.sdaLow   (sdaLowSlave),
		.txnCnt   (txnCnt),
		.doneCnt  (doneCnt),
		.readCnt  (readCnt),
		.ackCnt   (ackCnt),
		.adrsHist (adrsHist)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever
			#10 iSCLK = ~iSCLK;       // 20 ns period
	end

	// ----------------------------------------
	// Run limit
	// ----------------------------------------
	always @(posedge iSCLK)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleLimit > 0 && cycleCnt >= cycleLimit)
		begin
			$display("Run timed out after %0d clock cycles", cycleCnt);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		begin
			if (got !== exp)
			begin
				errCnt++;
				$display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
			end
		end
	endtask

	task automatic reportTest(input string name, input int errStart);
		begin
			if (errCnt == errStart)
			begin
				passTests++;
				$display("Test %s: ok", name);
			end
			else
			begin
				failTests++;
				$display("Test %s: failed with %0d errors", name, errCnt - errStart);
			end
		end
	endtask

	// Lines starting with # are column notes
	task automatic readStim;
		int          fd;
		int          n;
		string       line;
		logic [7:0]  k1;
		logic [7:0]  k2;
		logic [15:0] word;
		begin
			fd = $fopen("test/keypad_stim.txt", "r");
			if (fd == 0)
				$display("Could not open test/keypad_stim.txt");
			else
			begin
				while ($fgets(line, fd) > 0)
				begin
					if (line.len() > 0 && line.getc(0) != "#")
					begin
						n = $sscanf(line, "%h %h %h", k1, k2, word);
						if (n == 3)
						begin
							stimKey1.push_back(k1);
							stimKey2.push_back(k2);
							stimWord.push_back(word);
						end
					end
				end
				$fclose(fd);
			end
		end
	endtask

	// ----------------------------------------
	// One poll of both keypads
	// ----------------------------------------
	task automatic runPoll(input int idx);
		int txnStart;
		int doneStart;
		int readStart;
		int ackStart;
		int errStart;
		int lowCycles;
		begin
			errStart  = errCnt;
			txnStart  = txnCnt;
			doneStart = doneCnt;
			readStart = readCnt;
			ackStart  = ackCnt;
			lowCycles = 0;
			@(posedge iSCLK);
			key1Byte <= stimKey1[idx];
			key2Byte <= stimKey2[idx];
			en       <= 1'b1;
			@(negedge iSCLK);
			while (seqComp !== 1'b1)
				@(negedge iSCLK);
			// Both stops must come before completion shows
			compareValue(doneCnt - doneStart, 2, "stop conditions before completion");
			compareValue(txnCnt - txnStart, 2, "start conditions");
			compareValue(adrsHist, 16'h0203, "address bytes in order");
			compareValue(keyPad, stimWord[idx], "keypad word");
			compareValue(readCnt - readStart, 2, "read bytes");
			compareValue(ackCnt - ackStart, 2, "master acks on read bytes");
			repeat (HoldCycles)
			begin
				@(negedge iSCLK);
				if (seqComp !== 1'b1)
					lowCycles++;
			end
			compareValue(lowCycles, 0, "cycles with completion low while enabled");
			compareValue(txnCnt - txnStart, 2, "start conditions after hold");
			compareValue(keyPad, stimWord[idx], "keypad word after hold");
			@(posedge iSCLK);
			en <= 1'b0;
			@(negedge iSCLK);
			while (seqComp !== 1'b0)
				@(negedge iSCLK);
			repeat (4)
				@(posedge iSCLK);
			reportTest($sformatf("%0d keypads %h %h word %h", idx, stimKey1[idx],
				stimKey2[idx], keyPad), errStart);
		end
	endtask

	initial
	begin
		iSRST    = 1'b1;
		en       = 1'b0;
		key1Byte = 8'h00;
		key2Byte = 8'h00;
		readStim();
		if (stimWord.size() == 0)
		begin
			$display("No test vectors were read from the stim file");
			$display("STATUS: FAIL");
			$finish;
		end
		else
		begin
			cycleLimit = stimWord.size() * TestCycles + 200;
			repeat (5)
				@(posedge iSCLK);
			iSRST <= 1'b0;
			@(negedge iSCLK);
			compareValue(seqComp, 1'b0, "completion after reset");
			compareValue(keyPad, 16'h0000, "keypad word after reset");
			compareValue(scl, 1'b1, "SCL after reset");
			compareValue(sdaLowDut, 1'b0, "SDA pull-down after reset");
			reportTest("reset", 0);
			for (testIdx = 0; testIdx < stimWord.size(); testIdx++)
				runPoll(testIdx);
			$display("Tests %0d, passed %0d, failed %0d, errors %0d",
				passTests + failTests, passTests, failTests, errCnt);
			if (failTests == 0 && errCnt == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/keypad_stim.txt
# keypad 1 byte, keypad 2 byte, expected keypad word, all hex
# one poll per line, keypad 1 lands in the upper byte
5a c3 5ac3
00 00 0000
ff ff ffff
01 80 0180
80 01 8001
a5 5a a55a
3c 00 3c00
00 e7 00e7
7e 7e 7e7e

// File: sources.f
+incdir+rtl
rtl/I2CPkg.sv
rtl/I2CMasterMux.sv
rtl/I2CMaster.sv
rtl/I2CKeyPadTop.sv
test/I2CKeyPadSlave.sv
test/I2CKeyPadTb.sv

// File: Makefile
# Verilator build and run of the keypad I2C testbench
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP      = I2CKeyPadTb
FILELIST = sources.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with $(TOOL), run $(TOP), check $(LOG)"
	@echo "make clean  remove $(OBJDIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
